//--- logic/uart_pkg.sv
// ************************************************************
// UART echo subsystem shared definitions
// Baud timing, FIFO sizing, debounce timing and state types
// ************************************************************

`default_nettype none

package uart_pkg;

    // 156.25 MHz core clock, 115200 baud
    localparam int clks_per_bit  = 1356;
    localparam int baud_cnt_bits = $clog2(clks_per_bit);

    localparam int fifo_depth     = 16;
    localparam int fifo_addr_bits = 4;
    // CTS drops at or above this fill level
    localparam int cts_threshold  = 12;

    localparam int debounce_rate     = 156000;
    localparam int debounce_cnt_bits = $clog2(debounce_rate);
    localparam int debounce_samples  = 8;

    // 8 switches plus the centre button
    localparam int gpio_width = 9;

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } uart_rx_state_t;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } uart_tx_state_t;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
// ************************************************************
// UART receiver, 8N1
// Samples mid-bit and emits each good byte with a one-cycle
// strobe; frames with a low stop bit are dropped
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);

    logic                     rxd_meta;
    logic                     rxd_sync;
    uart_rx_state_t           state;
    logic [baud_cnt_bits-1:0] cnt;
    logic [2:0]               bit_idx;
    logic [7:0]               shreg;
    logic                     frame_err;

    // Two-flop synchroniser, idle level is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= rx_st_idle;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                rx_st_idle: begin
                    cnt <= '0;
                    // After a framing error wait for the line to go high again
                    if (frame_err) begin
                        frame_err <= !rxd_sync;
                    end else if (!rxd_sync) begin
                        state <= rx_st_start;
                    end
                end
                rx_st_start: begin
                    if (cnt == baud_cnt_bits'(clks_per_bit / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // Glitch filter, start bit must still be low at mid-bit
                        state   <= rxd_sync ? rx_st_idle : rx_st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_st_data: begin
                    if (cnt == baud_cnt_bits'(clks_per_bit - 1)) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_st_stop: begin
                    if (cnt == baud_cnt_bits'(clks_per_bit - 1)) begin
                        cnt       <= '0;
                        state     <= rx_st_idle;
                        rx_strobe <= rxd_sync;
                        frame_err <= !rxd_sync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_st_idle;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == rx_st_data && cnt == baud_cnt_bits'(clks_per_bit - 1)) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

    // Stable from the strobe until the next frame's first data bit
    assign rx_data = shreg;

endmodule

`default_nettype wire

//--- logic/byte_fifo.sv
// ************************************************************
// Byte FIFO, 16 entries
// Circular buffer with fill count and a registered CTS level
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module byte_fifo
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] wr_data,
    input  logic       wr_strobe,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       cts,
    input  logic       pop
);

    logic [7:0]                mem [fifo_depth];
    logic [fifo_addr_bits-1:0] wr_ptr;
    logic [fifo_addr_bits-1:0] rd_ptr;
    logic [fifo_addr_bits:0]   count;
    logic [fifo_addr_bits:0]   count_next;
    logic                      do_wr;
    logic                      do_rd;

    // Writes while full are dropped
    assign do_wr = wr_strobe && (count != (fifo_addr_bits + 1)'(fifo_depth));
    assign do_rd = pop && (count != '0);

    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            cts    <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            cts   <= count_next < (fifo_addr_bits + 1)'(cts_threshold);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
// ************************************************************
// UART transmitter, 8N1
// Pops bytes from the FIFO between frames while RTS is high
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] rd_data,
    input  logic       empty,
    input  logic       rts,
    output logic       pop,
    output logic       txd
);

    uart_tx_state_t           state;
    logic [baud_cnt_bits-1:0] cnt;
    logic [2:0]               bit_idx;
    logic [7:0]               shreg;
    logic                     bit_done;

    // RTS is only looked at here, a running frame always completes
    assign pop      = (state == tx_st_idle) && rts && !empty;
    assign bit_done = (cnt == baud_cnt_bits'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= tx_st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                tx_st_idle: begin
                    cnt <= '0;
                    txd <= 1'b1;
                    if (pop) begin
                        state <= tx_st_start;
                        txd   <= 1'b0;
                    end
                end
                tx_st_start: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        state   <= tx_st_data;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                    end
                end
                tx_st_data: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= tx_st_stop;
                            txd   <= 1'b1;
                        end else begin
                            txd <= shreg[1];
                        end
                    end
                end
                tx_st_stop: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        state <= tx_st_idle;
                    end
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

    // Byte is latched on pop, shifted after each data bit
    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= rd_data;
        end else if (state == tx_st_data && bit_done) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

//--- logic/debounce_switch.sv
// ************************************************************
// Switch and button debouncer
// Samples periodically; an output moves only after 8 equal
// samples of its input
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module debounce_switch
    import uart_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [gpio_width-1:0] in,
    output logic [gpio_width-1:0] out
);

    logic [debounce_cnt_bits-1:0] rate_cnt;
    logic                         tick;
    logic [debounce_samples-1:0]  hist [gpio_width];

    assign tick = (rate_cnt == debounce_cnt_bits'(debounce_rate - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= tick ? '0 : rate_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out <= '0;
            for (int i = 0; i < gpio_width; i++) begin
                hist[i] <= '0;
            end
        end else begin
            for (int i = 0; i < gpio_width; i++) begin
                if (tick) begin
                    hist[i] <= {hist[i][debounce_samples-2:0], in[i]};
                end
                // Mixed history keeps the previous output
                if (&hist[i]) begin
                    out[i] <= 1'b1;
                end else if (~|hist[i]) begin
                    out[i] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fpga_core.sv
// ************************************************************
// Board core logic
// UART echo through a byte FIFO with RTS/CTS, debounced GPIO
// and LED display of switches or the last received byte
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module fpga_core
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic       btnc,
    input  logic [7:0] sw,
    output logic [7:0] led,

    input  logic       uart_rxd,
    output logic       uart_txd,
    input  logic       uart_rts,
    output logic       uart_cts
);

    logic [7:0] rx_data;
    logic       rx_strobe;
    logic [7:0] rd_data;
    logic       empty;
    logic       pop;
    logic       btnc_db;
    logic [7:0] sw_db;
    logic [7:0] last_byte;

    debounce_switch i_debounce_switch (
        .clk    (clk),
        .arst_n (arst_n),
        .in     ({btnc, sw}),
        .out    ({btnc_db, sw_db})
    );

    uart_rx i_uart_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .rxd       (uart_rxd),
        .rx_data   (rx_data),
        .rx_strobe (rx_strobe)
    );

    byte_fifo i_byte_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_data   (rx_data),
        .wr_strobe (rx_strobe),
        .rd_data   (rd_data),
        .empty     (empty),
        .cts       (uart_cts),
        .pop       (pop)
    );

    uart_tx i_uart_tx (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_data (rd_data),
        .empty   (empty),
        .rts     (uart_rts),
        .pop     (pop),
        .txd     (uart_txd)
    );

    // Last good byte, shown while the centre button is held
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_byte <= '0;
            led       <= '0;
        end else begin
            if (rx_strobe) begin
                last_byte <= rx_data;
            end
            led <= btnc_db ? last_byte : sw_db;
        end
    end

endmodule

`default_nettype wire

//--- dv/fpga_core_checker.sv
// ************************************************************
// Protocol assertions for the board core
// Bound into fpga_core to watch its internal links
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module fpga_core_checker
    import uart_pkg::*;
(
    input logic           clk,
    input logic           arst_n,
    input logic           uart_txd,
    input uart_tx_state_t tx_state,
    input logic           pop,
    input logic           empty,
    input logic           rx_strobe
);

    int assert_fails = 0;
    int stored;

    // Bytes held in the FIFO as seen from its write and read strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stored <= 0;
        end else begin
            stored <= stored + int'(rx_strobe && (stored != fifo_depth)) - int'(pop);
        end
    end

    // Line sits at mark level between frames
    txd_idle_high: assert property (
        @(posedge clk) disable iff (!arst_n)
        (tx_state == tx_st_idle) |-> uart_txd
    ) else begin
        assert_fails++;
        $error("uart_txd low while the transmitter is idle");
    end

    // A FIFO with nothing stored reads as empty and is never popped
    pop_not_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        (stored == 0) |-> (empty && !pop)
    ) else begin
        assert_fails++;
        $error("pop asserted or empty clear while the FIFO holds no byte");
    end

    strobe_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        rx_strobe |=> !rx_strobe
    ) else begin
        assert_fails++;
        $error("rx_strobe held for more than one cycle");
    end

endmodule

`default_nettype wire

//--- dv/uart_scoreboard.sv
// ************************************************************
// UART echo scoreboard
// Decodes frames on uart_txd against a queue of expected
// bytes and compares other DUT outputs on request
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module uart_scoreboard
    import uart_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic uart_txd
);

    logic [7:0] exp_q [$];
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    int         bit_pos     = -1;
    int         clk_cnt     = 0;
    int         test_num    = 0;
    int         checks      = 0;
    int         errors      = 0;
    int         test_errors = 0;

    task automatic expect_byte(input logic [7:0] data);
        exp_q.push_back(data);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            test_errors++;
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        test_errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_errors == 0) begin
            $display("test %0d, %s: ok", test_num, name);
        end else begin
            $display("test %0d, %s: %0d errors", test_num, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic summary(input int assert_fails);
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_num, checks, errors, assert_fails);
    endtask

    // Frame decoder, counts from the first low sample
    always @(negedge clk) begin
        if (!arst_n) begin
            bit_pos = -1;
        end else if (bit_pos < 0) begin
            if (!uart_txd) begin
                bit_pos = 0;
                clk_cnt = 0;
            end
        end else begin
            clk_cnt++;
            if (clk_cnt == clks_per_bit / 2 + bit_pos * clks_per_bit) begin
                if (bit_pos == 0 && uart_txd) begin
                    report_error("uart_txd start bit is not low at mid-bit");
                    bit_pos = -1;
                end else if (bit_pos < 9) begin
                    // Data bits arrive LSB first
                    if (bit_pos > 0) begin
                        rx_byte = {uart_txd, rx_byte[7:1]};
                    end
                    bit_pos++;
                end else begin
                    if (!uart_txd) begin
                        report_error("uart_txd stop bit is low");
                    end
                    if (exp_q.size() == 0) begin
                        report_error($sformatf("byte %02h echoed with none expected", rx_byte));
                    end else begin
                        exp_byte = exp_q.pop_front();
                        check_value("uart_txd byte", int'(rx_byte), int'(exp_byte));
                    end
                    bit_pos = -1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_fpga_core.sv
// ************************************************************
// Testbench for the board core logic
// UART echo, RTS/CTS back-pressure, framing errors and LEDs
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_fpga_core
    import uart_pkg::*;
();

    localparam int frame_cycles  = 10 * clks_per_bit;
    // Worst case debounce delay plus the LED register
    localparam int settle_cycles = (debounce_samples + 1) * debounce_rate;
    localparam int run_limit     = 10_000_000;

    logic       clk;
    logic       arst_n;
    logic       btnc;
    logic [7:0] sw;
    logic [7:0] led;
    logic       uart_rxd;
    logic       uart_txd;
    logic       uart_rts;
    logic       uart_cts;
    // Model of FIFO fill and last good byte
    int         fill;
    logic [7:0] last_valid;

    fpga_core i_fpga_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .btnc     (btnc),
        .sw       (sw),
        .led      (led),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .uart_rts (uart_rts),
        .uart_cts (uart_cts)
    );

    uart_scoreboard i_uart_scoreboard (
        .clk      (clk),
        .arst_n   (arst_n),
        .uart_txd (uart_txd)
    );

    bind fpga_core fpga_core_checker i_fpga_core_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .uart_txd  (uart_txd),
        .tx_state  (i_uart_tx.state),
        .pop       (pop),
        .empty     (empty),
        .rx_strobe (rx_strobe)
    );

    // Reference model
    function automatic bit echo_kept(input int fill_lvl, input logic stop_bit);
        return stop_bit && (fill_lvl < fifo_depth);
    endfunction

    function automatic logic cts_level(input int fill_lvl);
        return fill_lvl < cts_threshold;
    endfunction

    function automatic logic [7:0] led_value(input logic btn, input logic [7:0] sw_v,
                                             input logic [7:0] last);
        return btn ? last : sw_v;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("ERROR at %0t: %s", $time, reason);
        $display("TEST FAIL");
        $finish;
    endtask

    initial begin
        repeat (run_limit) @(posedge clk);
        abort_run("simulation ran past its cycle limit");
    end

    // Inputs change 2 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [7:0] shifter;
        shifter  = data;
        uart_rxd = 1'b0;
        step_cycles(clks_per_bit);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = shifter[0];
            shifter  = shifter >> 1;
            step_cycles(clks_per_bit);
        end
        uart_rxd = stop_bit;
        step_cycles(clks_per_bit);
        uart_rxd = 1'b1;
    endtask

    task automatic send_modelled(input logic [7:0] data, input logic stop_bit);
        if (echo_kept(fill, stop_bit)) begin
            i_uart_scoreboard.expect_byte(data);
            if (!uart_rts) begin
                fill++;
            end
        end
        if (stop_bit) begin
            last_valid = data;
        end
        send_frame(data, stop_bit);
        // Idle gap lets the receiver leave its framing error state
        if (!stop_bit) begin
            step_cycles(clks_per_bit);
        end
    endtask

    task automatic wait_drain(input int limit, input string what);
        int n;
        n = 0;
        while (i_uart_scoreboard.pending() != 0) begin
            if (n == limit) begin
                abort_run({what, ": expected echo did not arrive in time"});
            end
            step_cycles(1);
            n++;
        end
        // Let the stop bit finish
        step_cycles(clks_per_bit);
    endtask

    task automatic wait_led(input logic [7:0] exp);
        int n;
        n = 0;
        while (led !== exp && n < settle_cycles) begin
            step_cycles(1);
            n++;
        end
        i_uart_scoreboard.check_value("led", int'(led), int'(exp));
    endtask

    initial begin
        int failures;
        void'($urandom(32'h5646852e));
        arst_n     = 1'b0;
        btnc       = 1'b0;
        sw         = 8'h00;
        uart_rxd   = 1'b1;
        uart_rts   = 1'b1;
        fill       = 0;
        last_valid = 8'h00;
        step_cycles(16);
        arst_n = 1'b1;
        step_cycles(1);

        i_uart_scoreboard.check_value("uart_txd", int'(uart_txd), 1);
        i_uart_scoreboard.check_value("uart_cts", int'(uart_cts), int'(cts_level(0)));
        i_uart_scoreboard.check_value("led", int'(led), int'(led_value(1'b0, 8'h00, 8'h00)));
        i_uart_scoreboard.end_test("values after reset");

        for (int i = 0; i < 8; i++) begin
            send_modelled(8'($urandom), 1'b1);
        end
        wait_drain(2 * frame_cycles, "random echo");
        i_uart_scoreboard.end_test("echo of random bytes");

        uart_rts = 1'b0;
        for (int i = 0; i < 20; i++) begin
            send_modelled(8'($urandom), 1'b1);
            i_uart_scoreboard.check_value("uart_cts", int'(uart_cts), int'(cts_level(fill)));
        end
        i_uart_scoreboard.check_value("queued echo count", i_uart_scoreboard.pending(), fill);
        uart_rts = 1'b1;
        wait_drain(17 * frame_cycles, "back-pressure");
        fill = 0;
        // Any byte past the first 16 would show up here as unexpected
        step_cycles(2 * frame_cycles);
        i_uart_scoreboard.check_value("uart_cts", int'(uart_cts), int'(cts_level(fill)));
        i_uart_scoreboard.end_test("RTS/CTS back-pressure");

        send_modelled(8'($urandom), 1'b0);
        send_modelled(8'($urandom), 1'b1);
        wait_drain(3 * frame_cycles, "framing error");
        i_uart_scoreboard.end_test("framing error drop");

        sw = 8'($urandom);
        wait_led(led_value(btnc, sw, last_valid));
        btnc = 1'b1;
        wait_led(led_value(btnc, sw, last_valid));
        btnc = 1'b0;
        wait_led(led_value(btnc, sw, last_valid));
        i_uart_scoreboard.end_test("LEDs from switches and button");

        failures = i_uart_scoreboard.errors + i_fpga_core.i_fpga_core_checker.assert_fails;
        i_uart_scoreboard.summary(i_fpga_core.i_fpga_core_checker.assert_fails);
        if (failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/uart_pkg.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/debounce_switch.sv
logic/fpga_core.sv
dv/fpga_core_checker.sv
dv/uart_scoreboard.sv
dv/tb_fpga_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the fpga_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_fpga_core -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench reaches its verdict
out=$(./obj_dir/Vtb_fpga_core +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
